//--- Makefile
# Verilator simulation of the frame-buffer testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run tb_framebuffer, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_framebuffer -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/sram_chip_model.sv
// Pipelined SRAM model with two-cycle read pipeline and late write data
`timescale 1ns/1ps

module sram_chip_model (
    input  logic                        clk,
    input  logic [fb_pkg::ADDR_W-1:0]   addr,
    input  logic                        we_n,
    input  logic                        ce_n,
    input  logic                        oe_n,
    input  logic                        adv_ld,
    input  logic                        cke_n,
    input  logic [fb_pkg::DQ_W-1:0]     dq_wr,
    input  logic                        dq_drive,
    output logic [fb_pkg::DQ_W-1:0]     dq_rd
);

    localparam int DEPTH = 1 << fb_pkg::ADDR_W;

    logic [fb_pkg::DQ_W-1:0]   mem [0:DEPTH-1];
    // Read pipe, address stage then data stage
    logic                      rd_s1;
    logic                      rd_s2;
    logic [fb_pkg::ADDR_W-1:0] rd_a1;
    logic [fb_pkg::DQ_W-1:0]   rd_q;
    // Write pipe, data arrives two edges after the address
    logic                      wr_s1;
    logic                      wr_s2;
    logic [fb_pkg::ADDR_W-1:0] wr_a1;
    logic [fb_pkg::ADDR_W-1:0] wr_a2;

    // Power-up image, depends on every address bit
    function automatic logic [15:0] fill_pixel(int a);
        return 16'(a) ^ 16'(a >> 4) ^ 16'h5a3c;
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {1'b0, fill_pixel(i)};
        end
        // Pipeline starts empty
        rd_s1 = 1'b0;
        rd_s2 = 1'b0;
        wr_s1 = 1'b0;
        wr_s2 = 1'b0;
    end

    always @(posedge clk) begin
        if (!cke_n) begin
            // Late write lands first, so a read in the same edge sees it
            if (wr_s2) begin
                mem[wr_a2] = dq_drive ? dq_wr : 'x;
            end
            rd_q  <= mem[rd_a1];
            rd_s2 <= rd_s1;
            wr_s2 <= wr_s1;
            wr_a2 <= wr_a1;
            rd_s1 <= !ce_n && we_n && !adv_ld;
            wr_s1 <= !ce_n && !we_n && !adv_ld;
            rd_a1 <= addr;
            wr_a1 <= addr;
        end
    end

    // Output enable gates the read data onto the bus
    assign dq_rd = (rd_s2 && !oe_n) ? rd_q : '0;

endmodule

//--- bench/tb_framebuffer.sv
// Frame-buffer testbench with random traffic, mirror image model and checks
`timescale 1ns/1ps

module tb_framebuffer;

    localparam int X_RES = 40;
    localparam int Y_RES = 30;
    localparam int PRECISION = 11;
    localparam int CW = PRECISION + 1;
    localparam int ADC_CW = fb_pkg::ADC_W - fb_pkg::ADC_X_LSB;
    localparam int ACK_TIMEOUT = 4 * fb_pkg::SRAM_DELAY;

    logic clk = 1'b0;
    logic arst_n;
    logic frozen;
    logic spi_pixel_ready, spi_pixel_read;
    logic [fb_pkg::PIXEL_W-1:0] spi_pixel_in;
    logic signed [PRECISION:0] spi_pixel_x, spi_pixel_y;
    logic [fb_pkg::ADC_W-1:0] adc_pixel_data;
    logic adc_pixel_ready, adc_pixel_read;
    logic request_active, request_ready;
    logic signed [PRECISION:0] request_x, request_y;
    logic [fb_pkg::PIXEL_W-1:0] request_data;
    logic [fb_pkg::ADDR_W-1:0] sram_addr;
    logic sram_we_n, sram_ce_n, sram_oe_n, sram_adv_ld, sram_cke_n, sram_clk;
    logic [fb_pkg::DQ_W-1:0] sram_dq_out, sram_dq_in;
    logic sram_dq_oe;

    integer seed;
    // Mirror image and the cycle of the last write per pixel
    logic [15:0] mirror [X_RES*Y_RES];
    int          last_wr [X_RES*Y_RES];
    // Expected read results packed as {ready, check data, data}
    logic [17:0] exp_q[$];
    int cyc, acks, checks, value_errors, other_errors;
    // Coordinates and pixel of the ADC word on offer
    int adc_x_cur, adc_y_cur;
    logic [15:0] adc_pix_cur;

    framebuffer_top #(.X_RES(X_RES), .Y_RES(Y_RES), .PRECISION(PRECISION)) DUT (.*);

    sram_chip_model u_sram (
        .clk(sram_clk), .addr(sram_addr), .we_n(sram_we_n), .ce_n(sram_ce_n),
        .oe_n(sram_oe_n), .adv_ld(sram_adv_ld), .cke_n(sram_cke_n),
        .dq_wr(sram_dq_out), .dq_drive(sram_dq_oe), .dq_rd(sram_dq_in)
    );

    always #5 clk = ~clk;

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic logic in_view(int x, int y);
        return x >= 0 && x < X_RES && y >= 0 && y < Y_RES;
    endfunction

    function automatic int pixel_addr(int x, int y);
        return y * X_RES + x;
    endfunction

    // Same power-up image as the chip model
    function automatic logic [15:0] fill_pixel(int a);
        return 16'(a) ^ 16'(a >> 4) ^ 16'h5a3c;
    endfunction

    function automatic logic [fb_pkg::ADC_W-1:0] pack_adc_word(int x, int y, logic [15:0] p);
        logic [fb_pkg::ADC_W-1:0] w;
        w = '0;
        w[fb_pkg::ADC_X_LSB +: ADC_CW] = ADC_CW'(x);
        w[fb_pkg::ADC_Y_LSB +: ADC_CW] = ADC_CW'(y);
        w[fb_pkg::PIXEL_W-1:0] = p;
        return w;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        checks++;
        assert (got === want) else begin
            value_errors++;
            $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    task automatic expect_true(logic ok, string what);
        checks++;
        assert (ok) else begin
            other_errors++;
            $display("ERROR t=%0t %s", $time, what);
        end
    endtask

    // Runs at the falling edge where inputs and outputs have settled
    task automatic monitor_cycle();
        logic [17:0] exp;
        logic        req_vis;
        logic        pop_exp;
        int          a;
        if (exp_q.size() == fb_pkg::SRAM_DELAY + 1) begin
            exp = exp_q.pop_front();
            check_value("request_ready", 32'(request_ready), 32'(exp[17]));
            if (exp[17] && exp[16]) begin
                check_value("request_data", 32'(request_data), 32'(exp[15:0]));
            end
        end
        req_vis = request_active && in_view(int'(request_x), int'(request_y));
        // ADC pops whenever ready and no visible read this cycle
        pop_exp = adc_pixel_ready && !req_vis;
        check_value("adc_pixel_read", 32'(adc_pixel_read), 32'(pop_exp));
        // Read result from writes of earlier cycles
        if (req_vis) begin
            a = pixel_addr(int'(request_x), int'(request_y));
            // Write one cycle before may or may not show
            exp = {1'b1, last_wr[a] != cyc - 1, mirror[a]};
        end else begin
            exp = {request_active, 1'b1, 16'h0000};
        end
        exp_q.push_back(exp);
        if (pop_exp && !frozen && in_view(adc_x_cur, adc_y_cur)) begin
            a = pixel_addr(adc_x_cur, adc_y_cur);
            mirror[a]  = adc_pix_cur;
            last_wr[a] = cyc;
        end
        if (spi_pixel_read) begin
            acks++;
            if (in_view(int'(spi_pixel_x), int'(spi_pixel_y))) begin
                a = pixel_addr(int'(spi_pixel_x), int'(spi_pixel_y));
                mirror[a]  = spi_pixel_in;
                last_wr[a] = cyc;
            end
        end
        cyc++;
    endtask

    // Observe the cycle and then move 1 ns past the next rising edge
    task automatic run_cycle();
        @(negedge clk);
        monitor_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(int n);
        for (int i = 0; i < n; i++) begin
            run_cycle();
        end
    endtask

    initial begin
        int n;
        int sx;
        int sy;
        int acks_before;
        int waited;
        seed = 32'hbd0e;
        arst_n = 1'b0;
        frozen = 1'b0;
        spi_pixel_ready = 1'b0;
        spi_pixel_in = '0;
        spi_pixel_x = '0;
        spi_pixel_y = '0;
        adc_pixel_data = '0;
        adc_pixel_ready = 1'b0;
        request_active = 1'b0;
        request_x = '0;
        request_y = '0;
        cyc = 0;
        acks = 0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        for (int i = 0; i < X_RES * Y_RES; i++) begin
            mirror[i]  = fill_pixel(i);
            last_wr[i] = -10;
        end

        // Reset for 8 cycles with the SRAM strobes idle
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_value("sram_we_n", 32'(sram_we_n), 1);
        check_value("sram_ce_n", 32'(sram_ce_n), 1);
        check_value("sram_oe_n", 32'(sram_oe_n), 1);
        check_value("sram_dq_oe", 32'(sram_dq_oe), 0);
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("request_ready", 32'(request_ready), 0);
        check_value("spi_pixel_read", 32'(spi_pixel_read), 0);
        check_value("adc_pixel_read", 32'(adc_pixel_read), 0);
        check_value("sram_we_n", 32'(sram_we_n), 1);
        check_value("sram_ce_n", 32'(sram_ce_n), 1);
        @(posedge clk);
        #1;
        for (int i = 0; i <= fb_pkg::SRAM_DELAY; i++) begin
            exp_q.push_back('0);
        end

        // Random reads and ADC words with the image frozen now and then
        for (n = 0; n < 800; n++) begin
            request_active  = 1'(rand_range(0, 1));
            request_x       = CW'(rand_range(-4, X_RES + 4));
            request_y       = CW'(rand_range(-4, Y_RES + 4));
            adc_pixel_ready = 1'(rand_range(0, 1));
            adc_x_cur       = rand_range(-4, X_RES + 4);
            adc_y_cur       = rand_range(-4, Y_RES + 4);
            adc_pix_cur     = 16'($random(seed));
            adc_pixel_data  = pack_adc_word(adc_x_cur, adc_y_cur, adc_pix_cur);
            frozen          = rand_range(0, 3) == 0;
            run_cycle();
        end
        request_active  = 1'b0;
        adc_pixel_ready = 1'b0;
        frozen          = 1'b1;
        idle_cycles(fb_pkg::SRAM_DELAY + 2);

        // Host pixels into the frozen image with one ack each and a read back
        for (n = 0; n < 16; n++) begin
            sx = rand_range(-4, X_RES + 4);
            sy = rand_range(-4, Y_RES + 4);
            spi_pixel_x     = CW'(sx);
            spi_pixel_y     = CW'(sy);
            spi_pixel_in    = 16'($random(seed));
            spi_pixel_ready = 1'b1;
            acks_before     = acks;
            waited          = 0;
            while (acks == acks_before && waited < ACK_TIMEOUT) begin
                run_cycle();
                waited++;
            end
            expect_true(acks == acks_before + 1, "SPI pixel got no acknowledge in time");
            spi_pixel_ready = 1'b0;
            idle_cycles(4);
            expect_true(acks == acks_before + 1, "SPI pixel acknowledged more than once");
            request_active = 1'b1;
            request_x      = CW'(sx);
            request_y      = CW'(sy);
            run_cycle();
            request_active = 1'b0;
        end
        idle_cycles(fb_pkg::SRAM_DELAY + 2);

        // Live image takes no host pixels
        frozen          = 1'b0;
        spi_pixel_x     = CW'(rand_range(0, X_RES - 1));
        spi_pixel_y     = CW'(rand_range(0, Y_RES - 1));
        spi_pixel_ready = 1'b1;
        acks_before     = acks;
        idle_cycles(ACK_TIMEOUT);
        expect_true(acks == acks_before, "SPI pixel acknowledged while not frozen");
        spi_pixel_ready = 1'b0;
        idle_cycles(fb_pkg::SRAM_DELAY + 2);

        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 checks, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- source/fb_adc_port.sv
// ADC write client with word unpacking, freeze and bounds filter, FIFO pop
`timescale 1ns/1ps

module fb_adc_port #(
    parameter int X_RES = 800,
    parameter int Y_RES = 600,
    parameter int PRECISION = 11
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           frozen,
    input  logic [fb_pkg::ADC_W-1:0]       adc_pixel_data,
    input  logic                           adc_pixel_ready,
    input  logic                           adc_grant,
    output logic                           adc_pixel_read,
    output logic                           adc_req,
    output logic [PRECISION-1:0]           adc_x,
    output logic [PRECISION-1:0]           adc_y,
    output logic [fb_pkg::PIXEL_W-1:0]     adc_pixel
);

    // Width of each coordinate field in the FIFO word
    localparam int COORD_W = fb_pkg::ADC_W - fb_pkg::ADC_X_LSB;

    logic [COORD_W-1:0] x_field;
    logic [COORD_W-1:0] y_field;
    logic               in_bounds;

    // Unpack the FIFO word
    assign x_field   = adc_pixel_data[fb_pkg::ADC_W-1:fb_pkg::ADC_X_LSB];
    assign y_field   = adc_pixel_data[fb_pkg::ADC_X_LSB-1:fb_pkg::ADC_Y_LSB];
    assign adc_pixel = adc_pixel_data[fb_pkg::ADC_Y_LSB-1:0];

    // Fields are unsigned, so only the upper limit matters
    assign in_bounds = x_field < X_RES && y_field < Y_RES;

    assign adc_x = x_field[PRECISION-1:0];
    assign adc_y = y_field[PRECISION-1:0];

    // Write only live, visible pixels
    assign adc_req = adc_pixel_ready && !frozen && in_bounds;

    // Pop whenever the read client leaves the cycle free
    // Dropped words are popped too, so the FIFO drains while frozen
    assign adc_pixel_read = adc_pixel_ready && adc_grant;

    // A pop always consumes a word the FIFO has offered
    pop_needs_ready_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(adc_pixel_read) |-> adc_pixel_ready
    );

endmodule

//--- source/fb_arbiter.sv
// Fixed-priority SRAM arbiter with address conversion and command register
`timescale 1ns/1ps

module fb_arbiter #(
    parameter int X_RES = 800,
    parameter int Y_RES = 600,
    parameter int PRECISION = 11
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           read_req,
    input  logic [PRECISION-1:0]           read_x,
    input  logic [PRECISION-1:0]           read_y,
    input  logic                           adc_req,
    input  logic [PRECISION-1:0]           adc_x,
    input  logic [PRECISION-1:0]           adc_y,
    input  logic [fb_pkg::PIXEL_W-1:0]     adc_pixel,
    input  logic                           spi_req,
    input  logic [PRECISION-1:0]           spi_x,
    input  logic [PRECISION-1:0]           spi_y,
    input  logic [fb_pkg::PIXEL_W-1:0]     spi_pixel,
    output logic                           adc_grant,
    output logic                           spi_grant,
    output logic                           cmd_valid,
    output logic                           cmd_we,
    output logic [fb_pkg::ADDR_W-1:0]      cmd_addr,
    output logic [fb_pkg::DQ_W-1:0]        cmd_data
);

    localparam int AW  = fb_pkg::ADDR_W;
    localparam int PAD = fb_pkg::DQ_W - fb_pkg::PIXEL_W;

    fb_pkg::src_e                src;
    logic [PRECISION-1:0]        sel_x;
    logic [PRECISION-1:0]        sel_y;
    logic [fb_pkg::PIXEL_W-1:0]  sel_data;
    logic [AW-1:0]               sel_addr;

    // Reads need no grant, they always win
    assign adc_grant = !read_req;
    assign spi_grant = !read_req && !adc_req;

    // Winner selection, read then ADC then SPI
    always_comb begin
        src      = fb_pkg::SRC_NONE;
        sel_x    = read_x;
        sel_y    = read_y;
        sel_data = '0;
        if (read_req) begin
            src = fb_pkg::SRC_READ;
        end else if (adc_req) begin
            src      = fb_pkg::SRC_ADC;
            sel_x    = adc_x;
            sel_y    = adc_y;
            sel_data = adc_pixel;
        end else if (spi_req) begin
            src      = fb_pkg::SRC_SPI;
            sel_x    = spi_x;
            sel_y    = spi_y;
            sel_data = spi_pixel;
        end
    end

    // One shared multiplier for all three clients
    assign sel_addr = AW'(sel_y) * AW'(X_RES) + AW'(sel_x);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
            cmd_we    <= 1'b0;
        end else begin
            cmd_valid <= src != fb_pkg::SRC_NONE;
            cmd_we    <= src == fb_pkg::SRC_ADC || src == fb_pkg::SRC_SPI;
        end
    end

    // Address and write data
    always_ff @(posedge clk) begin
        cmd_addr <= sel_addr;
        cmd_data <= {{PAD{1'b0}}, sel_data};
    end

    // At most one client actually served per cycle
    one_grant_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({read_req, adc_grant && adc_req, spi_grant && spi_req})
    );

    // Writes are only issued in cycles the read client left free
    no_write_over_read_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd_valid && cmd_we |-> !$past(read_req)
    );

    // Clients filter bounds, so every command stays inside the image
    addr_in_image_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd_valid |-> cmd_addr < X_RES * Y_RES
    );

endmodule

//--- source/fb_pkg.sv
// Frame-buffer widths, ADC word layout, SRAM latency and shared enums
package fb_pkg;

    // Pixel format, 16 bits per pixel
    localparam int PIXEL_W = 16;

    // External SRAM geometry
    localparam int ADDR_W = 20;
    // Top data bit has no use in the image and is written as zero
    localparam int DQ_W = 17;

    // ADC FIFO word, x in 37..27, y in 26..16, pixel in 15..0
    localparam int ADC_W = 38;
    localparam int ADC_X_LSB = 27;
    localparam int ADC_Y_LSB = 16;

    // Request to result, in cycles
    // Command register, pin register, two chip stages, capture and output
    localparam int SRAM_DELAY = 5;

    // Owner of the current SRAM access
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_READ,
        SRC_ADC,
        SRC_SPI
    } src_e;

    // SPI client states
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_WAIT,
        SPI_ACK
    } spi_state_e;

endpackage

//--- source/fb_read_port.sv
// Display read client with bounds check, in-flight tracking and pixel return
`timescale 1ns/1ps

module fb_read_port #(
    parameter int X_RES = 800,
    parameter int Y_RES = 600,
    parameter int PRECISION = 11
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           request_active,
    input  logic signed [PRECISION:0]      request_x,
    input  logic signed [PRECISION:0]      request_y,
    input  logic [fb_pkg::DQ_W-1:0]        rd_data,
    output logic                           read_req,
    output logic [PRECISION-1:0]           read_x,
    output logic [PRECISION-1:0]           read_y,
    output logic [fb_pkg::PIXEL_W-1:0]     request_data,
    output logic                           request_ready
);

    localparam int D = fb_pkg::SRAM_DELAY;

    logic         in_bounds;
    // One bit per request in flight with the oldest at the top
    logic [D-1:0] valid_pipe;
    logic [D-1:0] oob_pipe;

    // Signed compare so negative coordinates fall out here
    assign in_bounds = request_x >= 0 && request_x < X_RES &&
                       request_y >= 0 && request_y < Y_RES;

    // Only visible pixels go to the SRAM
    assign read_req = request_active && in_bounds;
    assign read_x   = request_x[PRECISION-1:0];
    assign read_y   = request_y[PRECISION-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe    <= '0;
            oob_pipe      <= '0;
            request_ready <= 1'b0;
        end else begin
            valid_pipe    <= {valid_pipe[D-2:0], request_active};
            oob_pipe      <= {oob_pipe[D-2:0], request_active && !in_bounds};
            request_ready <= valid_pipe[D-1];
        end
    end

    // Black for off-screen requests and the captured SRAM word otherwise
    always_ff @(posedge clk) begin
        if (oob_pipe[D-1]) begin
            request_data <= '0;
        end else begin
            request_data <= rd_data[fb_pkg::PIXEL_W-1:0];
        end
    end

    // Fixed latency through arbiter, SRAM port and chip
    // Ready rises at the D-th edge and is sampled high one edge later
    ready_after_request_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        $past(arst_n && request_active, D + 1) |-> request_ready
    );
    ready_only_for_request_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        request_ready |-> $past(request_active, D + 1)
    );

endmodule

//--- source/fb_spi_port.sv
// SPI write client FSM with fixed-delay acknowledge per host pixel
`timescale 1ns/1ps

module fb_spi_port #(
    parameter int X_RES = 800,
    parameter int Y_RES = 600,
    parameter int PRECISION = 11
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           frozen,
    input  logic                           spi_pixel_ready,
    input  logic [fb_pkg::PIXEL_W-1:0]     spi_pixel_in,
    input  logic signed [PRECISION:0]      spi_pixel_x,
    input  logic signed [PRECISION:0]      spi_pixel_y,
    input  logic                           spi_grant,
    output logic                           spi_pixel_read,
    output logic                           spi_req,
    output logic [PRECISION-1:0]           spi_x,
    output logic [PRECISION-1:0]           spi_y,
    output logic [fb_pkg::PIXEL_W-1:0]     spi_pixel
);

    localparam int CNT_W = $clog2(fb_pkg::SRAM_DELAY);
    // Reload value so the ack lands SRAM_DELAY edges after the grant
    localparam logic [CNT_W-1:0] WAIT_LOAD = CNT_W'(fb_pkg::SRAM_DELAY - 1);

    fb_pkg::spi_state_e state;
    logic [CNT_W-1:0]   cnt;
    logic               in_bounds;
    logic               pending;
    logic               start;

    assign in_bounds = spi_pixel_x >= 0 && spi_pixel_x < X_RES &&
                       spi_pixel_y >= 0 && spi_pixel_y < Y_RES;

    // Host pixels are only taken into a frozen image
    assign pending = state == fb_pkg::SPI_IDLE && spi_pixel_ready && frozen;
    assign spi_req = pending && in_bounds;
    // Off-screen pixels skip the SRAM but keep the same ack delay
    assign start   = (spi_req && spi_grant) || (pending && !in_bounds);

    assign spi_x     = spi_pixel_x[PRECISION-1:0];
    assign spi_y     = spi_pixel_y[PRECISION-1:0];
    assign spi_pixel = spi_pixel_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= fb_pkg::SPI_IDLE;
            cnt            <= '0;
            spi_pixel_read <= 1'b0;
        end else begin
            case (state)
                fb_pkg::SPI_IDLE: begin
                    if (start) begin
                        state <= fb_pkg::SPI_WAIT;
                        cnt   <= WAIT_LOAD;
                    end
                end
                fb_pkg::SPI_WAIT: begin
                    if (cnt == '0) begin
                        state          <= fb_pkg::SPI_ACK;
                        spi_pixel_read <= 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                fb_pkg::SPI_ACK: begin
                    // Pulse cycle and then one cycle for the host to drop ready
                    if (spi_pixel_read) begin
                        spi_pixel_read <= 1'b0;
                    end else begin
                        state <= fb_pkg::SPI_IDLE;
                    end
                end
                default: state <= fb_pkg::SPI_IDLE;
            endcase
        end
    end

    // Ack rises SRAM_DELAY edges after the pixel is taken
    ack_after_delay_a: assert property (
        @(posedge clk) disable iff (!arst_n)
        $past(arst_n && start, fb_pkg::SRAM_DELAY + 1) |-> spi_pixel_read
    );

endmodule

//--- source/framebuffer_top.sv
// Frame-buffer top with read, ADC and SPI clients, arbiter and SRAM port
`timescale 1ns/1ps

module framebuffer_top #(
    parameter int X_RES = 800,
    parameter int Y_RES = 600,
    parameter int PRECISION = 11
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           frozen,
    // SPI host pixel input
    input  logic                           spi_pixel_ready,
    output logic                           spi_pixel_read,
    input  logic [fb_pkg::PIXEL_W-1:0]     spi_pixel_in,
    input  logic signed [PRECISION:0]      spi_pixel_x,
    input  logic signed [PRECISION:0]      spi_pixel_y,
    // ADC FIFO
    input  logic [fb_pkg::ADC_W-1:0]       adc_pixel_data,
    input  logic                           adc_pixel_ready,
    output logic                           adc_pixel_read,
    // Display requests
    input  logic                           request_active,
    input  logic signed [PRECISION:0]      request_x,
    input  logic signed [PRECISION:0]      request_y,
    output logic [fb_pkg::PIXEL_W-1:0]     request_data,
    output logic                           request_ready,
    // SRAM pins, data bus split for the board-level pad
    output logic [fb_pkg::ADDR_W-1:0]      sram_addr,
    output logic                           sram_we_n,
    output logic                           sram_ce_n,
    output logic                           sram_oe_n,
    output logic                           sram_adv_ld,
    output logic                           sram_cke_n,
    output logic                           sram_clk,
    output logic [fb_pkg::DQ_W-1:0]        sram_dq_out,
    output logic                           sram_dq_oe,
    input  logic [fb_pkg::DQ_W-1:0]        sram_dq_in
);

    // Client requests and grants
    logic read_req, adc_req, spi_req;
    logic adc_grant, spi_grant;
    logic [PRECISION-1:0] read_x, read_y, adc_x, adc_y, spi_x, spi_y;
    logic [fb_pkg::PIXEL_W-1:0] adc_pixel, spi_pixel;

    // Registered command and read return
    logic cmd_valid, cmd_we;
    logic [fb_pkg::ADDR_W-1:0] cmd_addr;
    logic [fb_pkg::DQ_W-1:0] cmd_data, rd_data;

    fb_read_port #(.X_RES(X_RES), .Y_RES(Y_RES), .PRECISION(PRECISION))
        u_read_port (.*);

    fb_adc_port #(.X_RES(X_RES), .Y_RES(Y_RES), .PRECISION(PRECISION))
        u_adc_port (.*);

    fb_spi_port #(.X_RES(X_RES), .Y_RES(Y_RES), .PRECISION(PRECISION))
        u_spi_port (.*);

    fb_arbiter #(.X_RES(X_RES), .Y_RES(Y_RES), .PRECISION(PRECISION))
        u_arbiter (.*);

    sram_port u_sram_port (.*);

endmodule

//--- source/sram_port.sv
// Pipelined SRAM pin driver with delayed write data and read capture
`timescale 1ns/1ps

module sram_port (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cmd_valid,
    input  logic                        cmd_we,
    input  logic [fb_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [fb_pkg::DQ_W-1:0]     cmd_data,
    input  logic [fb_pkg::DQ_W-1:0]     sram_dq_in,
    output logic [fb_pkg::DQ_W-1:0]     rd_data,
    output logic [fb_pkg::ADDR_W-1:0]   sram_addr,
    output logic                        sram_we_n,
    output logic                        sram_ce_n,
    output logic                        sram_oe_n,
    output logic                        sram_adv_ld,
    output logic                        sram_cke_n,
    output logic                        sram_clk,
    output logic [fb_pkg::DQ_W-1:0]     sram_dq_out,
    output logic                        sram_dq_oe
);

    // Write is in its second cycle after the address
    logic                      wr_late;
    logic [fb_pkg::DQ_W-1:0]   wdata_a;
    logic [fb_pkg::DQ_W-1:0]   wdata_b;

    // Chip runs on our clock with clock enable on and a new address each cycle
    assign sram_clk    = clk;
    assign sram_cke_n  = 1'b0;
    assign sram_adv_ld = 1'b0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sram_ce_n  <= 1'b1;
            sram_we_n  <= 1'b1;
            sram_oe_n  <= 1'b1;
            wr_late    <= 1'b0;
            sram_dq_oe <= 1'b0;
        end else begin
            sram_ce_n  <= !cmd_valid;
            sram_we_n  <= !(cmd_valid && cmd_we);
            wr_late    <= !sram_we_n;
            // Drive the bus only in the write-data cycle
            sram_dq_oe <= wr_late;
            // Chip outputs off while we drive
            sram_oe_n  <= wr_late;
        end
    end

    // Address, two-stage write data and read capture
    always_ff @(posedge clk) begin
        sram_addr   <= cmd_addr;
        wdata_a     <= cmd_data;
        wdata_b     <= wdata_a;
        sram_dq_out <= wdata_b;
        rd_data     <= sram_dq_in;
    end

endmodule

//--- sources.f
source/fb_pkg.sv
source/fb_read_port.sv
source/fb_adc_port.sv
source/fb_spi_port.sv
source/fb_arbiter.sv
source/sram_port.sv
source/framebuffer_top.sv
bench/sram_chip_model.sv
bench/tb_framebuffer.sv
